// ==== logic/merge_cfg.svh ====
`ifndef MERGE_CFG_SVH
`define MERGE_CFG_SVH

// --------------------
// Record geometry
// --------------------

// Key and value widths in bits
`define MERGE_KEY_WIDTH   16
`define MERGE_VALUE_WIDTH 16

// Records per tuple, the network depth follows from it
`define MERGE_TUPLE_SIZE  4

// --------------------
// Buffering
// --------------------

// Default entries in each tuple FIFO
`define MERGE_FIFO_DEPTH  16

`endif

// ==== logic/record_pkg.sv ====
`include "merge_cfg.svh"

package record_pkg;

   // --------------------
   // Record
   // --------------------

   // One sort record, compared by key only
   typedef struct packed {
      logic [`MERGE_KEY_WIDTH-1:0]   key;
      logic [`MERGE_VALUE_WIDTH-1:0] value;
   } record_t;

   // --------------------
   // Tuple
   // --------------------

   // Records in ascending key order, element 0 has the smallest key
   typedef record_t [`MERGE_TUPLE_SIZE-1:0] tuple_t;

   // Key that a producer uses to flush the merger
   localparam logic [`MERGE_KEY_WIDTH-1:0] KEY_MAX = '1;

endpackage

// ==== logic/merge_ctrl_pkg.sv ====
package merge_ctrl_pkg;

   // --------------------
   // Control state
   // --------------------

   // ST_EMPTY until the first tuple sits in the held register
   typedef enum logic [0:0] {
      ST_EMPTY = 1'b0,
      ST_RUN   = 1'b1
   } merge_state_t;

   // --------------------
   // Issue word
   // --------------------

   // valid is also the dequeue of the chosen input FIFO
   typedef struct packed {
      logic valid;
      logic from_a;
      // First take only fills the held register
      logic load_only;
   } merge_issue_t;

endpackage

// ==== logic/tuple_fifo.sv ====
`timescale 1ns/1ps
`include "merge_cfg.svh"

module tuple_fifo #(
   parameter int DEPTH = `MERGE_FIFO_DEPTH
) (
   input  logic                        i_clk,
   input  logic                        i_reset,
   input  record_pkg::tuple_t          i_data,
   input  logic                        i_enq,
   input  logic                        i_deq,
   output record_pkg::tuple_t          o_data,
   output logic                        o_empty,
   output logic                        o_full,
   output logic [$clog2(DEPTH+1)-1:0]  o_free
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   record_pkg::tuple_t mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_enq;
   logic             do_deq;

   assign do_deq = i_deq & ~o_empty;
   // A full FIFO still takes a word when the head leaves in the same cycle
   assign do_enq = i_enq & (~o_full | do_deq);

   // --------------------
   // Pointers and count
   // --------------------

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_enq) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_deq) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (do_enq && !do_deq) begin
            count <= count + 1'b1;
         end else if (do_deq && !do_enq) begin
            count <= count - 1'b1;
         end
      end
   end

   // Storage
   always_ff @(posedge i_clk) begin
      if (do_enq) begin
         mem[wr_ptr] <= i_data;
      end
   end

   // Head is visible before it is dequeued
   assign o_data  = mem[rd_ptr];
   assign o_empty = (count == '0);
   assign o_full  = (count == CNT_W'(DEPTH));
   assign o_free  = CNT_W'(DEPTH) - count;

endmodule

// ==== logic/merge_control.sv ====
`timescale 1ns/1ps
`include "merge_cfg.svh"

module merge_control (
   input  logic                                   i_clk,
   input  logic                                   i_reset,
   input  record_pkg::tuple_t                     i_a_head,
   input  record_pkg::tuple_t                     i_b_head,
   input  logic                                   i_a_empty,
   input  logic                                   i_b_empty,
   input  logic [$clog2(`MERGE_FIFO_DEPTH+1)-1:0] i_out_free,
   output merge_ctrl_pkg::merge_issue_t           o_issue
);

   localparam int FREE_W = $clog2(`MERGE_FIFO_DEPTH + 1);

   // Output register plus one tuple on its way into the output FIFO
   localparam logic [FREE_W-1:0] MIN_FREE = FREE_W'(3);

   merge_ctrl_pkg::merge_state_t state;
   merge_ctrl_pkg::merge_state_t state_next;

   logic a_lte_b;
   logic room;
   logic take;

   // --------------------
   // Selection
   // --------------------

   // Smaller first key wins, A wins a tie
   assign a_lte_b = (i_a_head[0].key <= i_b_head[0].key);

   assign room = (i_out_free >= MIN_FREE);

   // Both heads must be present, or the choice could be wrong
   assign take = ~i_reset & ~i_a_empty & ~i_b_empty & room;

   assign o_issue.valid     = take;
   assign o_issue.from_a    = a_lte_b;
   assign o_issue.load_only = take & (state == merge_ctrl_pkg::ST_EMPTY);

   // --------------------
   // State
   // --------------------

   always_comb begin
      state_next = state;
      case (state)
         merge_ctrl_pkg::ST_EMPTY: begin
            if (take) begin
               state_next = merge_ctrl_pkg::ST_RUN;
            end
         end
         merge_ctrl_pkg::ST_RUN: begin
            state_next = merge_ctrl_pkg::ST_RUN;
         end
         default: begin
            state_next = merge_ctrl_pkg::ST_EMPTY;
         end
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         state <= merge_ctrl_pkg::ST_EMPTY;
      end else begin
         state <= state_next;
      end
   end

endmodule

// ==== logic/bitonic_merge_network.sv ====
`timescale 1ns/1ps
`include "merge_cfg.svh"

module bitonic_merge_network (
   input  record_pkg::tuple_t i_held,
   input  record_pkg::tuple_t i_new,
   output record_pkg::tuple_t o_low,
   output record_pkg::tuple_t o_high
);

   localparam int TS     = `MERGE_TUPLE_SIZE;
   localparam int N      = 2 * TS;
   localparam int LEVELS = $clog2(N);

   // lvl[0] is the bitonic input, lvl[LEVELS] is sorted
   record_pkg::record_t lvl [LEVELS+1][N];

   // --------------------
   // Bitonic input and compare-exchange
   // --------------------

   // Held ascending, then new reversed into descending order
   // Distances TS, TS/2 .. 1, whole records move so values stay with keys
   always_comb begin
      for (int i = 0; i < TS; i++) begin
         lvl[0][i]      = i_held[i];
         lvl[0][TS + i] = i_new[TS - 1 - i];
      end
      for (int k = 0; k < LEVELS; k++) begin
         for (int i = 0; i < N; i++) begin
            if ((i & (TS >> k)) == 0) begin
               if (lvl[k][i + (TS >> k)].key < lvl[k][i].key) begin
                  lvl[k+1][i]             = lvl[k][i + (TS >> k)];
                  lvl[k+1][i + (TS >> k)] = lvl[k][i];
               end else begin
                  lvl[k+1][i]             = lvl[k][i];
                  lvl[k+1][i + (TS >> k)] = lvl[k][i + (TS >> k)];
               end
            end
         end
      end
   end

   // Split the sorted eight into halves
   always_comb begin
      for (int i = 0; i < TS; i++) begin
         o_low[i]  = lvl[LEVELS][i];
         o_high[i] = lvl[LEVELS][TS + i];
      end
   end

endmodule

// ==== logic/tuple_merger.sv ====
`timescale 1ns/1ps
`include "merge_cfg.svh"

module tuple_merger (
   input  logic               i_clk,
   input  logic               i_reset,
   input  record_pkg::tuple_t i_a,
   input  record_pkg::tuple_t i_b,
   input  logic               i_a_empty,
   input  logic               i_b_empty,
   output logic               o_a_read,
   output logic               o_b_read,
   input  logic               i_out_ready,
   output record_pkg::tuple_t o_out,
   output logic               o_out_write
);

   localparam int FREE_W = $clog2(`MERGE_FIFO_DEPTH + 1);

   record_pkg::tuple_t a_head;
   record_pkg::tuple_t b_head;
   record_pkg::tuple_t chosen;
   record_pkg::tuple_t held;
   record_pkg::tuple_t net_low;
   record_pkg::tuple_t net_high;
   record_pkg::tuple_t out_data;

   logic              a_empty;
   logic              b_empty;
   logic              a_full;
   logic              b_full;
   logic              out_empty;
   logic [FREE_W-1:0] out_free;
   logic              out_valid;
   logic              ready_q;

   merge_ctrl_pkg::merge_issue_t issue;

   // --------------------
   // Input side
   // --------------------

   // A read during reset would be lost when the FIFO clears
   assign o_a_read = ~i_reset & ~i_a_empty & ~a_full;
   assign o_b_read = ~i_reset & ~i_b_empty & ~b_full;

   tuple_fifo #(.DEPTH(`MERGE_FIFO_DEPTH)) fifo_a (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_data  (i_a),
      .i_enq   (o_a_read),
      .i_deq   (issue.valid & issue.from_a),
      .o_data  (a_head),
      .o_empty (a_empty),
      .o_full  (a_full),
      .o_free  ()
   );

   tuple_fifo #(.DEPTH(`MERGE_FIFO_DEPTH)) fifo_b (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_data  (i_b),
      .i_enq   (o_b_read),
      .i_deq   (issue.valid & ~issue.from_a),
      .o_data  (b_head),
      .o_empty (b_empty),
      .o_full  (b_full),
      .o_free  ()
   );

   // --------------------
   // Merge
   // --------------------

   merge_control ctrl (
      .i_clk      (i_clk),
      .i_reset    (i_reset),
      .i_a_head   (a_head),
      .i_b_head   (b_head),
      .i_a_empty  (a_empty),
      .i_b_empty  (b_empty),
      .i_out_free (out_free),
      .o_issue    (issue)
   );

   assign chosen = issue.from_a ? a_head : b_head;

   bitonic_merge_network network (
      .i_held (held),
      .i_new  (chosen),
      .o_low  (net_low),
      .o_high (net_high)
   );

   // Upper half of each merge waits for the next take
   always_ff @(posedge i_clk) begin
      if (issue.valid) begin
         held <= issue.load_only ? chosen : net_high;
      end
   end

   always_ff @(posedge i_clk) begin
      if (issue.valid && !issue.load_only) begin
         out_data <= net_low;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         out_valid <= 1'b0;
         ready_q   <= 1'b0;
      end else begin
         out_valid <= issue.valid & ~issue.load_only;
         ready_q   <= i_out_ready;
      end
   end

   // --------------------
   // Output side
   // --------------------

   assign o_out_write = ~i_reset & ready_q & ~out_empty;

   tuple_fifo #(.DEPTH(`MERGE_FIFO_DEPTH)) fifo_out (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_data  (out_data),
      .i_enq   (out_valid),
      .i_deq   (o_out_write),
      .o_data  (o_out),
      .o_empty (out_empty),
      .o_full  (),
      .o_free  (out_free)
   );

endmodule

// ==== verification/tuple_merger_assertions.sv ====
`timescale 1ns/1ps
`include "merge_cfg.svh"

module tuple_merger_assertions (
   input logic               i_clk,
   input logic               i_reset,
   input logic               i_a_empty,
   input logic               i_b_empty,
   input logic               o_a_read,
   input logic               o_b_read,
   input logic               i_out_ready,
   input record_pkg::tuple_t o_out,
   input logic               o_out_write
);

   // --------------------
   // Handshakes
   // --------------------

   a_read_not_empty: assert property (@(posedge i_clk) disable iff (i_reset)
      o_a_read |-> !i_a_empty) else $error("read from input A while empty");

   b_read_not_empty: assert property (@(posedge i_clk) disable iff (i_reset)
      o_b_read |-> !i_b_empty) else $error("read from input B while empty");

   write_after_ready: assert property (@(posedge i_clk) disable iff (i_reset)
      o_out_write |-> $past(i_out_ready)) else $error("output write without ready");

   // Keys inside a written tuple rise from element 0
   out_ascending: assert property (@(posedge i_clk) disable iff (i_reset)
      o_out_write |-> (o_out[0].key <= o_out[1].key) && (o_out[1].key <= o_out[2].key)
                      && (o_out[2].key <= o_out[3].key))
      else $error("output tuple keys out of order");

   // --------------------
   // Reset
   // --------------------

   quiet_in_reset: assert property (@(posedge i_clk)
      i_reset |-> !o_a_read && !o_b_read && !o_out_write) else $error("strobe during reset");

   quiet_after_reset: assert property (@(posedge i_clk)
      $past(i_reset) && !i_reset |-> !o_out_write) else $error("write right after reset");

endmodule

bind tuple_merger tuple_merger_assertions tuple_merger_assertions_i (
   .i_clk       (i_clk),
   .i_reset     (i_reset),
   .i_a_empty   (i_a_empty),
   .i_b_empty   (i_b_empty),
   .o_a_read    (o_a_read),
   .o_b_read    (o_b_read),
   .i_out_ready (i_out_ready),
   .o_out       (o_out),
   .o_out_write (o_out_write)
);

// ==== verification/tuple_merger_tb.sv ====
`timescale 1ns/1ps
`include "merge_cfg.svh"

module tuple_merger_tb;

   localparam int KW = `MERGE_KEY_WIDTH;
   localparam int TS = `MERGE_TUPLE_SIZE;
   localparam logic [31:0] SEED = 32'h5c66_6f2c;
   localparam logic [`MERGE_VALUE_WIDTH-1:0] VALUE_MASK = 16'ha5a5;

   // Key generation modes
   localparam int MODE_RANDOM = 0;
   localparam int MODE_BELOW  = 1;
   localparam int MODE_INTER  = 2;
   localparam int MODE_DUPS   = 3;

   typedef struct packed {
      int n_a;
      int n_b;
      int mode;
      int ready_pct;
      int gap_pct;
   } test_entry_t;

   localparam int NUM_TESTS = 6;
   localparam test_entry_t TESTS [NUM_TESTS] = '{
      '{8,  8,  MODE_RANDOM, 100, 0},
      '{12, 9,  MODE_RANDOM, 60,  20},
      '{10, 10, MODE_RANDOM, 15,  10},
      '{5,  11, MODE_BELOW,  70,  30},
      '{9,  9,  MODE_INTER,  80,  10},
      '{10, 7,  MODE_DUPS,   50,  25}
   };

   logic               i_clk;
   logic               i_reset;
   record_pkg::tuple_t i_a;
   record_pkg::tuple_t i_b;
   logic               i_a_empty;
   logic               i_b_empty;
   logic               o_a_read;
   logic               o_b_read;
   logic               i_out_ready;
   record_pkg::tuple_t o_out;
   logic               o_out_write;

   logic [31:0]         rng_state;
   record_pkg::tuple_t  stream_a[$];
   record_pkg::tuple_t  stream_b[$];
   logic [KW-1:0]       golden[$];
   record_pkg::record_t rx[$];
   int                  head_a;
   int                  head_b;
   int                  pass_count;
   int                  fail_count;

   tuple_merger tuple_merger_i (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_a         (i_a),
      .i_b         (i_b),
      .i_a_empty   (i_a_empty),
      .i_b_empty   (i_b_empty),
      .o_a_read    (o_a_read),
      .o_b_read    (o_b_read),
      .i_out_ready (i_out_ready),
      .o_out       (o_out),
      .o_out_write (o_out_write)
   );

   always #5 i_clk = ~i_clk;

   // --------------------
   // Random helpers
   // --------------------

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic int unsigned rand_below(input int unsigned n);
      rng_state = xorshift32(rng_state);
      return rng_state % n;
   endfunction

   function automatic bit chance(input int pct);
      return int'(rand_below(100)) < pct;
   endfunction

   // Keys stay below the sentinel key in every mode
   function automatic logic [KW-1:0] gen_key(input int mode, input bit is_b, input int j);
      case (mode)
         MODE_BELOW: begin
            return is_b ? KW'(32'h8000 + rand_below(32'h4000)) : KW'(rand_below(32'h4000));
         end
         MODE_INTER: begin
            return is_b ? KW'(4 * j + 2) : KW'(4 * j);
         end
         MODE_DUPS: begin
            return KW'(rand_below(8));
         end
         default: begin
            return KW'(rand_below(32'hfff0));
         end
      endcase
   endfunction

   function automatic record_pkg::record_t to_record(input logic [KW-1:0] key);
      record_pkg::record_t rec;
      rec.key   = key;
      rec.value = key ^ VALUE_MASK;
      return rec;
   endfunction

   // --------------------
   // Stimulus and golden
   // --------------------

   task automatic build_streams(input test_entry_t t);
      logic [KW-1:0]      ka[$];
      logic [KW-1:0]      kb[$];
      record_pkg::tuple_t tup;
      for (int j = 0; j < TS * t.n_a; j++) begin
         ka.push_back(gen_key(t.mode, 1'b0, j));
      end
      for (int j = 0; j < TS * t.n_b; j++) begin
         kb.push_back(gen_key(t.mode, 1'b1, j));
      end
      ka.sort();
      kb.sort();
      golden.delete();
      foreach (ka[i]) golden.push_back(ka[i]);
      foreach (kb[i]) golden.push_back(kb[i]);
      golden.sort();
      stream_a.delete();
      stream_b.delete();
      for (int n = 0; n < t.n_a; n++) begin
         for (int r = 0; r < TS; r++) tup[r] = to_record(ka[TS * n + r]);
         stream_a.push_back(tup);
      end
      for (int n = 0; n < t.n_b; n++) begin
         for (int r = 0; r < TS; r++) tup[r] = to_record(kb[TS * n + r]);
         stream_b.push_back(tup);
      end
      // Flush tuple at the end of each stream
      for (int r = 0; r < TS; r++) tup[r] = to_record(record_pkg::KEY_MAX);
      stream_a.push_back(tup);
      stream_b.push_back(tup);
   endtask

   // One clock of both producers, the consumer and the output monitor
   task automatic clock_cycle(input test_entry_t t, input bit ready_high);
      if (head_a < stream_a.size()) begin
         i_a       <= stream_a[head_a];
         i_a_empty <= chance(t.gap_pct);
      end else begin
         i_a_empty <= 1'b1;
      end
      if (head_b < stream_b.size()) begin
         i_b       <= stream_b[head_b];
         i_b_empty <= chance(t.gap_pct);
      end else begin
         i_b_empty <= 1'b1;
      end
      i_out_ready <= ready_high || chance(t.ready_pct);
      @(negedge i_clk);
      if (o_a_read) head_a++;
      if (o_b_read) head_b++;
      if (o_out_write) begin
         for (int r = 0; r < TS; r++) rx.push_back(o_out[r]);
      end
      @(posedge i_clk);
   endtask

   task automatic run_test(input int num, input test_entry_t t);
      int n_real;
      int n_seen;
      int bad;
      n_real = TS * (t.n_a + t.n_b);
      bad    = 0;
      build_streams(t);
      head_a = 0;
      head_b = 0;
      rx.delete();
      @(posedge i_clk);
      i_reset     <= 1'b1;
      // Producers already offer data, the DUT must still not read it
      i_a         <= stream_a[0];
      i_b         <= stream_b[0];
      i_a_empty   <= 1'b0;
      i_b_empty   <= 1'b0;
      i_out_ready <= 1'b1;
      repeat (2) begin
         @(negedge i_clk);
         assert (!o_a_read && !o_b_read && !o_out_write) else begin
            $display("Strobe active while reset is high in test %0d", num);
            bad++;
         end
         @(posedge i_clk);
      end
      i_reset <= 1'b0;
      while (rx.size() < n_real) clock_cycle(t, 1'b0);
      // Nothing more may follow the last real record
      n_seen = rx.size();
      repeat (10) clock_cycle(t, 1'b1);
      assert (rx.size() == n_seen) else begin
         $display("Extra output tuples after the last real record in test %0d", num);
         bad++;
      end
      assert (rx.size() == n_real) else begin
         $display("error: o_out record count expected 0x%h actual 0x%h", n_real, rx.size());
         bad++;
      end
      for (int i = 0; i < n_real && i < rx.size() && bad < 10; i++) begin
         assert (rx[i].key == golden[i]) else begin
            $display("error: o_out key %0d expected 0x%h actual 0x%h", i, golden[i], rx[i].key);
            bad++;
         end
         assert (rx[i].value == (golden[i] ^ VALUE_MASK)) else begin
            $display("error: o_out value %0d expected 0x%h actual 0x%h",
                     i, golden[i] ^ VALUE_MASK, rx[i].value);
            bad++;
         end
      end
      $display("test %0d mode %0d: %0d records, %s", num, t.mode, rx.size(),
               (bad == 0) ? "ok" : "FAILED");
      if (bad == 0) pass_count++;
      else fail_count++;
   endtask

   // --------------------
   // Main and watchdog
   // --------------------

   initial begin
      i_clk       = 1'b0;
      i_reset     = 1'b1;
      i_a         = '0;
      i_b         = '0;
      i_a_empty   = 1'b1;
      i_b_empty   = 1'b1;
      i_out_ready = 1'b0;
      rng_state   = SEED;
      pass_count  = 0;
      fail_count  = 0;
      for (int i = 0; i < NUM_TESTS; i++) run_test(i, TESTS[i]);
      $display("%0d tests ok, %0d tests failed", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin : watchdog
      int limit;
      limit = 1000;
      for (int i = 0; i < NUM_TESTS; i++) limit += 200 * (TESTS[i].n_a + TESTS[i].n_b + 2);
      repeat (limit) @(posedge i_clk);
      $display("Watchdog expired after %0d cycles, the merger stopped producing output", limit);
      $display("Test failures found");
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+logic
logic/record_pkg.sv
logic/merge_ctrl_pkg.sv
logic/tuple_fifo.sv
logic/merge_control.sv
logic/bitonic_merge_network.sv
logic/tuple_merger.sv
verification/tuple_merger_assertions.sv
verification/tuple_merger_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the tuple merger testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tuple_merger_tb -o tuple_merger_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tuple_merger_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test failures found" "$LOG"; then
   exit 1
fi
exit 0
